/* compile.f */
src/rv_pkg.sv
src/uart_rx.sv
src/prog_loader.sv
src/byte_mem.sv
src/reg_file.sv
src/rv_core.sv
src/rv_uart_top.sv
tests/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the rv_uart_top testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f compile.f --top-module tb_rv_core -Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$log"; then
    echo "FAIL"
    exit 1
fi

if ! grep -q "all tests passed" "$log"; then
    echo "no result found in $log"
    exit 1
fi

echo "PASS"
exit 0

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    // own copy of the uart bit period
    localparam int bit_clks = 16;
    // five loads of at most 14k cycles each with double margin
    localparam int load_cycles = 14000;
    localparam int max_cycles  = 5 * load_cycles * 2 + 10000;
    localparam int marker_wait = 2000;

    // rv32i major opcodes
    localparam logic [6:0] opc_lui    = 7'h37;
    localparam logic [6:0] opc_imm    = 7'h13;
    localparam logic [6:0] opc_reg    = 7'h33;
    localparam logic [6:0] opc_load   = 7'h03;
    localparam logic [6:0] opc_store  = 7'h23;
    localparam logic [6:0] opc_branch = 7'h63;
    localparam logic [6:0] opc_jal    = 7'h6f;

    logic        clk;
    logic        rst;
    logic        prog;
    logic        rx;
    logic        tx;
    logic        debug;
    logic [4:0]  debug_input;
    logic [31:0] debug_output;

    logic [31:0] code[$];
    logic [15:0] lfsr = 16'd10287;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    rv_uart_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .prog         (prog),
        .rx           (rx),
        .tx           (tx),
        .debug        (debug),
        .debug_input  (debug_input),
        .debug_output (debug_output)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // hard stop if a wait never ends
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_reg};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc_store};
    endfunction

    // branch offset bits 12:1 scattered over the word
    function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return i_type(imm, rs1, 0, rd, opc_imm);
    endfunction

    // lui then addi with the upper part bumped when addi sign extends negative
    task automatic load_const(int rd, logic [31:0] v);
        logic [19:0] upper;
        upper = v[31:12] + {19'b0, v[11]};
        code.push_back({upper, rd[4:0], opc_lui});
        code.push_back(addi(rd, rd, int'(v)));
    endtask

    // done marker in x31 then spin on a jal to itself
    task automatic end_program(int id);
        code.push_back(addi(31, 0, id));
        code.push_back(j_type(0, 0));
    endtask

    //////////////////////////////////////////////////////////////////////
    // random bits
    //////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // serial load and debug access
    //////////////////////////////////////////////////////////////////////

    // 8n1 frame lsb first and entered right after a rising edge
    task automatic uart_send(logic [7:0] b);
        rx <= 1'b0;
        repeat (bit_clks) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            rx <= b[i];
            repeat (bit_clks) @(posedge clk);
        end
        rx <= 1'b1;
        repeat (bit_clks) @(posedge clk);
    endtask

    task automatic load_program();
        @(posedge clk);
        prog <= 1'b1;
        repeat (4) @(posedge clk);
        foreach (code[w]) begin
            for (int k = 0; k < 4; k++) begin
                uart_send(code[w][8*k +: 8]);
            end
        end
        // last word write lands before prog drops
        repeat (4) @(posedge clk);
        prog <= 1'b0;
    endtask

    // debug read is combinational so sample mid cycle
    task automatic read_reg(int idx, output logic [31:0] v);
        @(posedge clk);
        debug_input <= idx[4:0];
        @(negedge clk);
        v = debug_output;
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(int idx, logic [31:0] exp);
        logic [31:0] v;
        read_reg(idx, v);
        check($sformatf("x%0d", idx), v, exp);
    endtask

    // poll x31 until the program reports its id
    task automatic wait_marker(int id);
        logic [31:0] v;
        int          n;
        n = 0;
        read_reg(31, v);
        while (v != id && n < marker_wait) begin
            read_reg(31, v);
            n++;
        end
        if (v != id) begin
            errors++;
            $display("program %0d did not reach its end marker in %0d cycles", id, n);
        end
    endtask

    task automatic report_test(string name, int errs_before);
        $display("%s: done, %0d mismatches", name, errors - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic arith_ops();
        logic [31:0] a;
        logic [31:0] b;
        int          sh1;
        int          sh2;
        int          e0;
        e0  = errors;
        // no transmitter so the line idles high
        check("tx", {31'b0, tx}, 32'd1);
        a   = rand_bits(32);
        b   = rand_bits(32);
        sh1 = rand_bits(5);
        sh2 = rand_bits(5);
        code.delete();
        load_const(1, a);
        load_const(2, b);
        code.push_back(r_type(0, 2, 1, 0, 10));
        code.push_back(r_type(32, 2, 1, 0, 11));
        code.push_back(r_type(0, 2, 1, 7, 12));
        code.push_back(r_type(0, 2, 1, 6, 13));
        code.push_back(r_type(0, 2, 1, 4, 14));
        code.push_back(r_type(0, 2, 1, 2, 15));
        code.push_back(i_type(sh1, 1, 1, 16, opc_imm));
        code.push_back(i_type(sh2, 2, 5, 17, opc_imm));
        end_program(1);
        load_program();
        wait_marker(1);
        check_reg(1, a);
        check_reg(2, b);
        check_reg(10, a + b);
        check_reg(11, a - b);
        check_reg(12, a & b);
        check_reg(13, a | b);
        check_reg(14, a ^ b);
        check_reg(15, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        check_reg(16, a << sh1);
        check_reg(17, b >> sh2);
        report_test("arith", e0);
    endtask

    task automatic load_store();
        logic [31:0] w;
        logic [7:0]  bytes [4];
        int          e0;
        e0 = errors;
        w  = rand_bits(32);
        code.delete();
        load_const(5, w);
        code.push_back(s_type(12'h200, 5, 0, 2));
        code.push_back(i_type(12'h200, 0, 2, 6, opc_load));
        // one sb per lane of the next word
        for (int k = 0; k < 4; k++) begin
            bytes[k] = rand_bits(8);
            code.push_back(addi(7, 0, int'(bytes[k])));
            code.push_back(s_type(12'h204 + k, 7, 0, 0));
        end
        code.push_back(i_type(12'h204, 0, 2, 11, opc_load));
        for (int k = 0; k < 4; k++) begin
            code.push_back(i_type(12'h204 + k, 0, 4, 12 + k, opc_load));
        end
        end_program(2);
        load_program();
        wait_marker(2);
        check_reg(6, w);
        // byte k sits on bits 8k+7:8k
        check_reg(11, {bytes[3], bytes[2], bytes[1], bytes[0]});
        for (int k = 0; k < 4; k++) begin
            check_reg(12 + k, {24'b0, bytes[k]});
        end
        report_test("load/store", e0);
    endtask

    task automatic control_flow();
        int n;
        int e0;
        e0 = errors;
        n  = (rand_bits(4) % 15) + 1;
        code.delete();
        code.push_back(addi(3, 0, 0));
        code.push_back(addi(5, 0, n));
        code.push_back(addi(3, 3, 1));
        code.push_back(b_type(-4, 5, 3, 1));
        code.push_back(addi(6, 0, 0));
        code.push_back(addi(9, 0, 0));
        // beq skips the write to x6
        code.push_back(b_type(8, 0, 0, 0));
        code.push_back(addi(6, 0, 99));
        // jal at word 8 skips the write to x9
        code.push_back(j_type(8, 7));
        code.push_back(addi(9, 0, 77));
        end_program(3);
        load_program();
        wait_marker(3);
        check_reg(3, n);
        check_reg(6, 32'd0);
        check_reg(7, 32'd36);
        check_reg(9, 32'd0);
        report_test("control", e0);
    endtask

    task automatic debug_halt();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        int          e0;
        e0 = errors;
        code.delete();
        code.push_back(addi(31, 0, 4));
        code.push_back(addi(4, 0, 0));
        code.push_back(addi(4, 4, 1));
        code.push_back(j_type(-4, 0));
        load_program();
        wait_marker(4);
        repeat (50) @(posedge clk);
        debug <= 1'b1;
        // let the current instruction finish
        repeat (20) @(posedge clk);
        read_reg(4, v1);
        repeat (100) @(posedge clk);
        read_reg(4, v2);
        check("x4 frozen", v2, v1);
        @(posedge clk);
        debug <= 1'b0;
        repeat (100) @(posedge clk);
        read_reg(4, v3);
        check("x4 advances", {31'b0, v3 > v2}, 32'd1);
        report_test("debug", e0);
    endtask

    // another load without a reset in between
    task automatic reprogram();
        int e0;
        e0 = errors;
        code.delete();
        code.push_back(addi(20, 0, 341));
        code.push_back(addi(21, 20, -100));
        code.push_back(addi(0, 0, 60));
        code.push_back(r_type(0, 20, 0, 0, 22));
        end_program(5);
        load_program();
        wait_marker(5);
        check_reg(20, 32'd341);
        check_reg(21, 32'd241);
        check_reg(0, 32'd0);
        check_reg(22, 32'd341);
        report_test("reprogram", e0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst         <= 1'b1;
        prog        <= 1'b0;
        rx          <= 1'b1;
        debug       <= 1'b0;
        debug_input <= 5'd0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        arith_ops();
        load_store();
        control_flow();
        debug_halt();
        reprogram();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* src/rv_uart_top.sv */
`timescale 1ns/1ps

module rv_uart_top
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            prog,
    input  logic            rx,
    output logic            tx,
    input  logic            debug,
    input  logic [4:0]      debug_input,
    output logic [xlen-1:0] debug_output
);

    logic [7:0]      rx_data;
    logic            rx_valid;
    logic            ld_wr;
    mem_req_t        ld_req;
    logic            core_rd;
    mem_req_t        core_req;
    logic [xlen-1:0] core_rdata;
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            rd_we;
    logic [4:0]      rd_idx;
    logic [xlen-1:0] rd_val;

    // no transmitter, line stays idle
    assign tx = 1'b1;

    uart_rx uart_rx_i (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .data       (rx_data),
        .data_valid (rx_valid)
    );

    prog_loader prog_loader_i (
        .clk        (clk),
        .rst        (rst),
        .prog       (prog),
        .data       (rx_data),
        .data_valid (rx_valid),
        .wr         (ld_wr),
        .req        (ld_req)
    );

    // port a loads, port b belongs to the core
    byte_mem byte_mem_i (
        .clk     (clk),
        .a_wr    (ld_wr),
        .a_req   (ld_req),
        .b_rd    (core_rd),
        .b_req   (core_req),
        .b_rdata (core_rdata)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst      (rst),
        .we       (rd_we),
        .waddr    (rd_idx),
        .wdata    (rd_val),
        .raddr1   (rs1_idx),
        .raddr2   (rs2_idx),
        .rdata1   (rs1_val),
        .rdata2   (rs2_val),
        .dbg_addr (debug_input),
        .dbg_data (debug_output)
    );

    // core held at pc zero while loading
    rv_core rv_core_i (
        .clk       (clk),
        .rst       (rst),
        .hold      (prog),
        .debug     (debug),
        .mem_rd    (core_rd),
        .mem_req   (core_req),
        .mem_rdata (core_rdata),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .rd_we     (rd_we),
        .rd_idx    (rd_idx),
        .rd_val    (rd_val)
    );

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            hold,
    input  logic            debug,
    output logic            mem_rd,
    output mem_req_t        mem_req,
    input  logic [xlen-1:0] mem_rdata,
    output logic [4:0]      rs1_idx,
    output logic [4:0]      rs2_idx,
    input  logic [xlen-1:0] rs1_val,
    input  logic [xlen-1:0] rs2_val,
    output logic            rd_we,
    output logic [4:0]      rd_idx,
    output logic [xlen-1:0] rd_val
);

    core_state_e     state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] npc;
    logic [xlen-1:0] alu_res;
    decoded_t        dec;
    decoded_t        dn;
    logic [xlen-1:0] ins;
    logic [2:0]      f3;
    logic            ok;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;
    logic            br_taken;
    logic [xlen-1:0] ld_shift;

    //////////////////////////////////////////////////////////////////////
    // decoder, fed straight from memory read data
    //////////////////////////////////////////////////////////////////////

    assign ins = mem_rdata;
    assign f3  = ins[14:12];

    always_comb begin
        dn     = '0;
        ok     = 1'b1;
        dn.op  = opcode_e'(ins[6:0]);
        dn.rd  = ins[11:7];
        dn.rs1 = ins[19:15];
        dn.rs2 = ins[24:20];
        dn.alu = alu_add;
        // i-type immediate by default
        dn.imm = {{20{ins[31]}}, ins[31:20]};
        case (dn.op)
            op_lui: begin
                dn.alu       = alu_pass_b;
                dn.imm       = {ins[31:12], 12'b0};
                dn.use_imm   = 1'b1;
                dn.reg_write = 1'b1;
            end
            op_imm, op_reg: begin
                dn.use_imm   = (dn.op == op_imm);
                dn.reg_write = 1'b1;
                case (f3)
                    3'b000: dn.alu = (dn.op == op_reg && ins[30]) ? alu_sub : alu_add;
                    3'b001: dn.alu = alu_sll;
                    3'b100: dn.alu = alu_xor;
                    3'b110: dn.alu = alu_or;
                    3'b111: dn.alu = alu_and;
                    3'b010: begin
                        // slt only in register form
                        dn.alu = alu_slt;
                        ok     = (dn.op == op_reg);
                    end
                    3'b101: begin
                        // arithmetic shift not supported
                        dn.alu = alu_srl;
                        ok     = !ins[30];
                    end
                    default: ok = 1'b0;
                endcase
            end
            op_load: begin
                dn.use_imm     = 1'b1;
                dn.reg_write   = 1'b1;
                dn.is_load     = 1'b1;
                dn.byte_access = (f3 == 3'b100);
                ok             = (f3 == 3'b010) || (f3 == 3'b100);
            end
            op_store: begin
                dn.imm         = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                dn.use_imm     = 1'b1;
                dn.is_store    = 1'b1;
                dn.byte_access = (f3 == 3'b000);
                ok             = (f3 == 3'b000) || (f3 == 3'b010);
            end
            op_branch: begin
                dn.imm       = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                dn.branch_ne = f3[0];
                // beq and bne only
                ok           = (f3[2:1] == 2'b00);
            end
            op_jal: begin
                dn.imm       = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                dn.reg_write = 1'b1;
            end
            default: ok = 1'b0;
        endcase
        // anything else becomes a no-op
        if (!ok) begin
            dn = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // alu and branch unit
    //////////////////////////////////////////////////////////////////////

    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

    always_comb begin
        opb = dec.use_imm ? dec.imm : rs2_val;
        case (dec.alu)
            alu_add:    alu_y = rs1_val + opb;
            alu_sub:    alu_y = rs1_val - opb;
            alu_and:    alu_y = rs1_val & opb;
            alu_or:     alu_y = rs1_val | opb;
            alu_xor:    alu_y = rs1_val ^ opb;
            alu_sll:    alu_y = rs1_val << opb[4:0];
            alu_srl:    alu_y = rs1_val >> opb[4:0];
            alu_slt:    alu_y = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(opb)};
            alu_pass_b: alu_y = opb;
            default:    alu_y = '0;
        endcase
        pc_plus4 = pc + 32'd4;
        // bne flips the equality result
        br_taken = (dec.op == op_branch) && ((rs1_val == rs2_val) != dec.branch_ne);
        pc_next  = (br_taken || dec.op == op_jal) ? pc + dec.imm : pc_plus4;
    end

    //////////////////////////////////////////////////////////////////////
    // control fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || hold) begin
            state <= st_fetch;
            pc    <= '0;
        end else begin
            case (state)
                // debug only looked at between instructions
                st_fetch:  state <= debug ? st_halt : st_decode;
                st_decode: state <= st_exec;
                st_exec:   state <= (dec.is_load || dec.is_store) ? st_mem : st_wb;
                st_mem: begin
                    if (dec.is_load) begin
                        state <= st_wb;
                    end else begin
                        pc    <= npc;
                        state <= st_fetch;
                    end
                end
                st_wb: begin
                    pc    <= npc;
                    state <= st_fetch;
                end
                st_halt: begin
                    if (!debug) begin
                        state <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // instruction and result registers
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            dec <= dn;
        end
        if (state == st_exec) begin
            // jal links pc+4
            alu_res <= (dec.op == op_jal) ? pc_plus4 : alu_y;
            npc     <= pc_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory port and writeback
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_rd       = (state == st_fetch) && !debug;
        mem_req      = '0;
        mem_req.addr = pc[mem_aw+1:2];
        if (state == st_mem) begin
            mem_req.addr = alu_res[mem_aw+1:2];
            mem_rd       = dec.is_load;
            if (dec.is_store && dec.byte_access) begin
                // byte k sits on bits 8k+7:8k
                mem_req.be    = 4'b0001 << alu_res[1:0];
                mem_req.wdata = {4{rs2_val[7:0]}};
            end else if (dec.is_store) begin
                mem_req.be    = 4'hf;
                mem_req.wdata = rs2_val;
            end
        end
    end

    // lbu pulls the addressed lane down and zero extends
    assign ld_shift = mem_rdata >> {alu_res[1:0], 3'b000};

    always_comb begin
        rd_we  = (state == st_wb) && dec.reg_write;
        rd_idx = dec.rd;
        rd_val = alu_res;
        if (dec.is_load) begin
            rd_val = dec.byte_access ? {24'b0, ld_shift[7:0]} : mem_rdata;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    input  logic [4:0]      dbg_addr,
    output logic [xlen-1:0] dbg_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            // x0 never written so it reads zero
            regs[waddr] <= wdata;
        end
    end

    // async reads, debug port included
    assign rdata1   = regs[raddr1];
    assign rdata2   = regs[raddr2];
    assign dbg_data = regs[dbg_addr];

endmodule

/* src/byte_mem.sv */
`timescale 1ns/1ps

module byte_mem
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            a_wr,
    input  mem_req_t        a_req,
    input  logic            b_rd,
    input  mem_req_t        b_req,
    output logic [xlen-1:0] b_rdata
);

    logic [xlen-1:0] mem [mem_words];

    always_ff @(posedge clk) begin
        // per lane writes, port a is the loader, port b the core
        for (int k = 0; k < 4; k++) begin
            if (a_wr && a_req.be[k]) begin
                mem[a_req.addr][8*k +: 8] <= a_req.wdata[8*k +: 8];
            end
            if (b_req.be[k]) begin
                mem[b_req.addr][8*k +: 8] <= b_req.wdata[8*k +: 8];
            end
        end
        // registered read, data one cycle after strobe
        if (b_rd) begin
            b_rdata <= mem[b_req.addr];
        end
    end

endmodule

/* src/prog_loader.sv */
`timescale 1ns/1ps

module prog_loader
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       prog,
    input  logic [7:0] data,
    input  logic       data_valid,
    output logic       wr,
    output mem_req_t   req
);

    logic              prog_q;
    logic              take;
    logic [1:0]        byte_cnt;
    logic [mem_aw-1:0] word_addr;
    logic [xlen-1:0]   word;

    // bytes only count while loading
    assign take = prog && data_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_q    <= 1'b0;
            byte_cnt  <= '0;
            word_addr <= '0;
            wr        <= 1'b0;
        end else begin
            prog_q <= prog;
            // fourth byte completes the word
            wr     <= take && (byte_cnt == 2'd3);
            if (prog && !prog_q) begin
                // new load starts at word zero
                byte_cnt  <= '0;
                word_addr <= '0;
            end else begin
                if (take) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
                if (wr) begin
                    word_addr <= word_addr + 1'b1;
                end
            end
        end
    end

    // little endian, first byte ends up in bits 7:0
    always_ff @(posedge clk) begin
        if (take) begin
            word <= {data, word[xlen-1:8]};
        end
    end

    always_comb begin
        req.addr  = word_addr;
        req.be    = {4{wr}};
        req.wdata = word;
    end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] data,
    output logic       data_valid
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    rx_state_e          state;
    logic [1:0]         rx_sync;
    logic               rx_s;
    logic [baud_cw-1:0] cnt;
    logic [2:0]         bit_idx;

    // two flop synchronizer, line idles high
    assign rx_s = rx_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync    <= 2'b11;
            state      <= rx_idle;
            cnt        <= '0;
            bit_idx    <= '0;
            data_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], rx};
            data_valid <= 1'b0;
            cnt        <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    // falling edge opens a frame
                    if (!rx_s) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // mid start bit, glitch goes back to idle
                    if (cnt == baud_half) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (cnt == baud_last) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                rx_stop: begin
                    // low stop bit drops the frame
                    if (cnt == baud_last) begin
                        data_valid <= rx_s;
                        state      <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == rx_data && cnt == baud_last) begin
            data <= {rx_s, data[7:1]};
        end
    end

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int xlen      = 32;
    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);

    // uart bit period in clocks
    localparam int clks_per_bit = 16;
    localparam int baud_cw      = $clog2(clks_per_bit);
    // sample point inside the start bit
    localparam logic [baud_cw-1:0] baud_half = baud_cw'(clks_per_bit / 2 - 1);
    localparam logic [baud_cw-1:0] baud_last = baud_cw'(clks_per_bit - 1);

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // rv32i major opcodes, subset only
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_wb,
        st_halt
    } core_state_e;

    // one memory request, be all zero means read or idle
    typedef struct packed {
        logic [mem_aw-1:0] addr;
        logic [3:0]        be;
        logic [xlen-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        opcode_e         op;
        alu_op_e         alu;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
        logic            use_imm;
        logic            reg_write;
        logic            is_load;
        logic            is_store;
        logic            byte_access;
        logic            branch_ne;
    } decoded_t;

endpackage
